// ==== rtl/edge_counter.sv ====
// Rising-edge counter in simple slot 1
// Counts 0-to-1 changes on one selectable input pin

module edge_counter
    import periph_pkg::*;
#(
    parameter int COUNT_W = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_sel,
    input  logic [3:0]       i_reg,
    input  logic [7:0]       i_data,
    input  logic [1:0]       i_data_write_n,
    input  logic [PIN_W-1:0] i_ui_in,
    output logic [7:0]       o_rdata,
    output logic [PIN_W-1:0] o_pins
);

    logic [2:0]         pin_sel;
    logic               prev_level;
    logic               cur_level;
    logic               wr_en;
    logic [COUNT_W-1:0] count;

    assign cur_level = i_ui_in[pin_sel];
    assign wr_en     = i_sel && i_data_write_n != RW_IDLE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel    <= '0;
            prev_level <= 1'b0;
            count      <= '0;
        end else begin
            prev_level <= cur_level;
            if (wr_en && i_reg == EDGE_OFS_SEL) begin
                pin_sel    <= i_data[2:0];
                // Resample so switching pins is not taken as an edge
                prev_level <= i_ui_in[i_data[2:0]];
            end

            if (wr_en && i_reg == EDGE_OFS_COUNT) begin
                count <= '0;
            end else if (cur_level && !prev_level) begin
                count <= count + 1'b1;  // wraps at the top
            end
        end
    end

    always_comb begin
        case (i_reg)
            EDGE_OFS_SEL:   o_rdata = {5'b0, pin_sel};
            EDGE_OFS_COUNT: o_rdata = 8'(count);
            default:        o_rdata = 8'h00;
        endcase
    end

    // The count is also shown on the pins
    assign o_pins = PIN_W'(count);

endmodule

// ==== rtl/gpio_regs.sv ====
// GPIO block in user slot 1
// Output register, input readback and the per-pin output function selects

module gpio_regs
    import periph_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_sel,
    input  logic [ADDR_W-1:0]             i_addr,
    input  logic [DATA_W-1:0]             i_data,
    input  logic [1:0]                    i_data_write_n,
    input  logic [PIN_W-1:0]              i_ui_in,
    output logic [DATA_W-1:0]             o_rdata,
    output logic [PIN_W-1:0]              o_gpio_out,
    output logic [PIN_W-1:0][FSEL_W-1:0]  o_fsel
);

    periph_addr_t                 addr;
    logic [5:0]                   ofs;
    logic                         wr_en;
    logic                         fsel_hit;
    logic [2:0]                   fsel_idx;
    logic [PIN_W-1:0]             gpio_out;
    logic [PIN_W-1:0][FSEL_W-1:0] fsel;

    assign addr  = i_addr;
    assign ofs   = addr.user.reg_ofs;
    assign wr_en = i_sel && i_data_write_n != RW_IDLE;

    // Function selects sit at 0x20..0x3c, word aligned
    assign fsel_hit = (ofs & 6'h23) == GPIO_FSEL_BASE;
    assign fsel_idx = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && ofs == GPIO_OFS_OUT) begin
            gpio_out <= i_data[PIN_W-1:0];
        end
    end

    // All pins start out driven by GPIO
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fsel <= {PIN_W{{2'b00, SLOT_GPIO}}};
        end else if (wr_en && fsel_hit) begin
            fsel[fsel_idx] <= i_data[FSEL_W-1:0];
        end
    end

    always_comb begin
        o_rdata = '0;
        if (ofs == GPIO_OFS_OUT) begin
            o_rdata[PIN_W-1:0] = gpio_out;
        end else if (ofs == GPIO_OFS_IN) begin
            o_rdata[PIN_W-1:0] = i_ui_in;
        end else if (fsel_hit) begin
            o_rdata[FSEL_W-1:0] = fsel[fsel_idx];
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_fsel     = fsel;

endmodule

// ==== rtl/periph_decode.sv ====
// Peripheral address decoder
// Selects the addressed slot and muxes its read data and ready

module periph_decode
    import periph_pkg::*;
(
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_gpio_data,
    input  logic [7:0]        i_edge_data,
    output logic              o_sel_gpio,
    output logic              o_sel_edge,
    output logic [DATA_W-1:0] o_peri_data,
    output logic              o_peri_ready
);

    periph_addr_t addr;
    logic         simple_space;

    assign addr = i_addr;

    // Region tag 10 marks the 16-byte simple slots, anything else is user space
    assign simple_space = addr.simple.region == REGION_SIMPLE;

    assign o_sel_edge = simple_space && addr.simple.slot == SLOT_EDGE;
    assign o_sel_gpio = !simple_space && !addr.user.bank && addr.user.slot == SLOT_GPIO;

    // Unpopulated slots read as zero
    always_comb begin
        o_peri_data = '0;
        if (o_sel_gpio) begin
            o_peri_data = i_gpio_data;
        end else if (o_sel_edge) begin
            o_peri_data = {{(DATA_W-8){1'b0}}, i_edge_data};
        end
    end

    // Every slot, populated or not, answers in the cycle it is addressed
    assign o_peri_ready = 1'b1;

endmodule

// ==== rtl/periph_pkg.sv ====
// Peripheral hub shared definitions
// Bus widths, slot numbers, register offsets and the address views

package periph_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int PIN_W  = 8;
    localparam int FSEL_W = 6;

    // Slot numbers in user and simple space
    localparam logic [3:0] SLOT_GPIO = 4'd1;
    localparam logic [3:0] SLOT_EDGE = 4'd1;

    // GPIO register offsets, function selects are 4 bytes apart
    localparam logic [5:0] GPIO_OFS_OUT   = 6'h00;
    localparam logic [5:0] GPIO_OFS_IN    = 6'h04;
    localparam logic [5:0] GPIO_FSEL_BASE = 6'h20;

    // Edge counter byte registers
    localparam logic [3:0] EDGE_OFS_SEL   = 4'h0;
    localparam logic [3:0] EDGE_OFS_COUNT = 4'h1;

    // Strobe code for no access
    localparam logic [1:0] RW_IDLE = 2'b11;

    // Region tag of simple-slot space
    localparam logic [1:0] REGION_SIMPLE = 2'b10;

    typedef union packed {
        struct packed {
            logic       bank;
            logic [3:0] slot;
            logic [5:0] reg_ofs;
        } user;
        struct packed {
            logic [1:0] region;
            logic       spare;
            logic [3:0] slot;
            logic [3:0] reg_ofs;
        } simple;
    } periph_addr_t;

endpackage

// ==== rtl/periph_read_reg.sv ====
// Read data register toward the core
// Captures peripheral read data and holds it until the core completes the read

module periph_read_reg
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        i_data_read_n,
    input  logic [1:0]        i_data_write_n,
    input  logic              i_data_read_complete,
    input  logic [DATA_W-1:0] i_peri_data,
    input  logic              i_peri_ready,
    output logic [DATA_W-1:0] o_data_out,
    output logic              o_data_ready,
    output logic [1:0]        o_read_n_masked
);

    logic              hold;
    logic              ready_r;
    logic [DATA_W-1:0] data_r;
    logic              read_req;
    logic              capture;

    // No new read reaches the peripherals while a result is being returned
    assign o_read_n_masked = i_data_read_n | {2{ready_r}};
    assign read_req        = o_read_n_masked != RW_IDLE;
    assign capture         = !hold && read_req && i_peri_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= read_req && i_peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_peri_data;
        end
    end

    assign o_data_out   = data_r;
    assign o_data_ready = ready_r || i_data_write_n != RW_IDLE;

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ready_r) |-> $past(i_data_read_n != RW_IDLE))
        else $error("periph_read_reg: data ready without a read strobe");

endmodule

// ==== rtl/periph_top.sv ====
// Peripheral hub top level
// Connects decode, read register, GPIO, edge counter and pin multiplexer

module periph_top
    import periph_pkg::*;
#(
    parameter int COUNT_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [PIN_W-1:0]  i_ui_in,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data,
    input  logic [1:0]        i_data_write_n,
    input  logic [1:0]        i_data_read_n,
    input  logic              i_data_read_complete,
    output logic [DATA_W-1:0] o_data_out,
    output logic              o_data_ready,
    output logic [PIN_W-1:0]  o_uo_out
);

    logic                         sel_gpio;
    logic                         sel_edge;
    logic [DATA_W-1:0]            peri_data;
    logic                         peri_ready;
    logic [DATA_W-1:0]            gpio_rdata;
    logic [7:0]                   edge_rdata;
    logic [PIN_W-1:0]             gpio_pins;
    logic [PIN_W-1:0]             edge_pins;
    logic [PIN_W-1:0][FSEL_W-1:0] fsel;

    periph_decode u_decode (
        .i_addr       (i_addr),
        .i_gpio_data  (gpio_rdata),
        .i_edge_data  (edge_rdata),
        .o_sel_gpio   (sel_gpio),
        .o_sel_edge   (sel_edge),
        .o_peri_data  (peri_data),
        .o_peri_ready (peri_ready)
    );

    // Masked read strobe is for peripherals with read side effects, none here
    periph_read_reg u_read_reg (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .i_peri_data          (peri_data),
        .i_peri_ready         (peri_ready),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_read_n_masked      ()
    );

    gpio_regs u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_sel          (sel_gpio),
        .i_addr         (i_addr),
        .i_data         (i_data),
        .i_data_write_n (i_data_write_n),
        .i_ui_in        (i_ui_in),
        .o_rdata        (gpio_rdata),
        .o_gpio_out     (gpio_pins),
        .o_fsel         (fsel)
    );

    edge_counter #(
        .COUNT_W (COUNT_W)
    ) u_edge (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_sel          (sel_edge),
        .i_reg          (i_addr[3:0]),
        .i_data         (i_data[7:0]),
        .i_data_write_n (i_data_write_n),
        .i_ui_in        (i_ui_in),
        .o_rdata        (edge_rdata),
        .o_pins         (edge_pins)
    );

    pin_mux u_pin_mux (
        .i_fsel      (fsel),
        .i_gpio_pins (gpio_pins),
        .i_edge_pins (edge_pins),
        .o_uo_out    (o_uo_out)
    );

endmodule

// ==== rtl/pin_mux.sv ====
// Output pin multiplexer
// Each pin takes its bit from whichever peripheral its function select names

module pin_mux
    import periph_pkg::*;
(
    input  logic [PIN_W-1:0][FSEL_W-1:0] i_fsel,
    input  logic [PIN_W-1:0]             i_gpio_pins,
    input  logic [PIN_W-1:0]             i_edge_pins,
    output logic [PIN_W-1:0]             o_uo_out
);

    for (genvar i = 0; i < PIN_W; i++) begin : g_pin
        logic [FSEL_W-1:0] sel;
        logic              pin_val;

        assign sel = i_fsel[i];

        // Bit 4 picks simple space, bits 5 and 3:0 give the user slot
        always_comb begin
            pin_val = 1'b0;
            if (sel[4]) begin
                if (sel[3:0] == SLOT_EDGE) begin
                    pin_val = i_edge_pins[i];
                end
            end else if ({sel[5], sel[3:0]} == {1'b0, SLOT_GPIO}) begin
                pin_val = i_gpio_pins[i];
            end
        end

        assign o_uo_out[i] = pin_val;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the hub testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_periph_top \
    && ./obj_dir/Vtb_periph_top | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// ==== sim/bus_patterns.txt ====
// Columns: op, address, data, expected (hex)
// op 1 write, 2 read, 3 set ui_in, 4 check uo_out, 5 toggle (address = levels, data = mask), f end
2 040 00000000 00000000
2 060 00000000 00000001
2 064 00000000 00000001
2 068 00000000 00000001
2 06c 00000000 00000001
2 070 00000000 00000001
2 074 00000000 00000001
2 078 00000000 00000001
2 07c 00000000 00000001
4 000 00000000 00000000
1 040 000000a5 00000000
4 000 00000000 000000a5
2 040 00000000 000000a5
3 000 0000005c 00000000
2 044 00000000 0000005c
2 080 00000000 00000000
2 420 00000000 00000000
1 410 00000001 00000000
2 410 00000000 00000001
5 258 00000002 00000000
2 411 00000000 0000002c
5 00a 00000001 00000000
2 411 00000000 0000002c
1 06c 00000011 00000000
1 07c 00000011 00000000
2 07c 00000000 00000011
4 000 00000000 0000002d
1 411 00000000 00000000
2 411 00000000 00000000
4 000 00000000 00000025
f 000 00000000 00000000

// ==== sim/tb_periph_top.sv ====
// Testbench for the peripheral hub
// Replays bus patterns from a data file and checks read data and output pins

module tb_periph_top;
    timeunit 1ns;
    timeprecision 100ps;

    import periph_pkg::*;

    localparam int MAX_OPS    = 64;
    localparam int WAIT_LIMIT = 20;

    localparam logic [31:0] OP_WRITE  = 32'h1;
    localparam logic [31:0] OP_READ   = 32'h2;
    localparam logic [31:0] OP_SET    = 32'h3;
    localparam logic [31:0] OP_CHECK  = 32'h4;
    localparam logic [31:0] OP_TOGGLE = 32'h5;
    localparam logic [31:0] OP_END    = 32'hf;

    logic              clk;
    logic              rst_n;
    logic [PIN_W-1:0]  i_ui_in;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] i_data;
    logic [1:0]        i_data_write_n;
    logic [1:0]        i_data_read_n;
    logic              i_data_read_complete;
    logic [DATA_W-1:0] o_data_out;
    logic              o_data_ready;
    logic [PIN_W-1:0]  o_uo_out;

    // Four words per operation, in file column order
    logic [31:0] patterns [0:4*MAX_OPS-1];
    int          errors;
    int          checks;
    bit          timed_out;

    periph_top #(
        .COUNT_W (8)
    ) dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("[ERROR] %s = %h, expected %h", name, actual, expected);
        end
    endtask

    // Sampled on the falling edge, away from the DUT's clock edge
    task automatic wait_ready(input logic [ADDR_W-1:0] addr);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_data_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_data_ready) begin
            $display("Timed out waiting for data ready at address %h", addr);
            timed_out = 1'b1;
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        i_addr         <= addr;
        i_data         <= data;
        i_data_write_n <= 2'b10;
        wait_ready(addr);
        @(posedge clk);
        i_data_write_n <= RW_IDLE;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected);
        @(posedge clk);
        i_addr        <= addr;
        i_data_read_n <= 2'b10;
        wait_ready(addr);
        check_value("o_data_out", o_data_out, expected);
        @(posedge clk);
        i_data_read_n <= RW_IDLE;
        i_addr        <= addr ^ 11'h004;
        // Data must stay put until the read is completed, even with the address moved
        @(negedge clk);
        check_value("o_data_out", o_data_out, expected);
        // Ready lasts a single cycle
        check_value("o_data_ready", {31'b0, o_data_ready}, 32'h0);
        @(posedge clk);
        i_data_read_complete <= 1'b1;
        @(posedge clk);
        i_data_read_complete <= 1'b0;
    endtask

    // One level change per cycle on the masked pins
    task automatic toggle_pins(input int levels, input logic [PIN_W-1:0] mask);
        logic [PIN_W-1:0] level;
        level = i_ui_in;
        for (int n = 0; n < levels; n++) begin
            @(posedge clk);
            level = level ^ mask;
            i_ui_in <= level;
        end
    endtask

    initial begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        int          idx;
        bit          done;

        rst_n                = 1'b0;
        i_ui_in              = '0;
        i_addr               = '0;
        i_data               = '0;
        i_data_write_n       = RW_IDLE;
        i_data_read_n        = RW_IDLE;
        i_data_read_complete = 1'b0;
        errors               = 0;
        checks               = 0;
        timed_out            = 1'b0;
        done                 = 1'b0;
        idx                  = 0;

        $readmemh("sim/bus_patterns.txt", patterns);

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        while (!done && !timed_out && idx < MAX_OPS) begin
            op       = patterns[4*idx];
            addr     = patterns[4*idx+1];
            data     = patterns[4*idx+2];
            expected = patterns[4*idx+3];
            case (op)
                OP_WRITE:  bus_write(addr[ADDR_W-1:0], data);
                OP_READ:   bus_read(addr[ADDR_W-1:0], expected);
                OP_SET: begin
                    @(posedge clk);
                    i_ui_in <= data[PIN_W-1:0];
                end
                OP_CHECK: begin
                    @(negedge clk);
                    check_value("o_uo_out", {24'b0, o_uo_out}, expected);
                end
                OP_TOGGLE: toggle_pins(int'(addr), data[PIN_W-1:0]);
                OP_END:    done = 1'b1;
                default: begin
                    $display("Unknown operation %h in pattern %0d", op, idx);
                    errors++;
                    done = 1'b1;
                end
            endcase
            idx++;
        end

        if (!done && !timed_out) begin
            $display("Pattern file ended without an end marker");
            errors++;
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/periph_pkg.sv
rtl/periph_decode.sv
rtl/periph_read_reg.sv
rtl/gpio_regs.sv
rtl/edge_counter.sv
rtl/pin_mux.sv
rtl/periph_top.sv
sim/tb_periph_top.sv
